// ==== build.f ====
design/video_pkg.sv
design/video_if.sv
design/raster_counter.sv
design/sync_fsm.sv
design/pattern_gen.sv
design/axil_regs.sv
design/video_pattern_top.sv
bench/tb_video_pattern.sv

// ==== Makefile ====
# Verilator simulation of the video pattern source

VERILATOR  ?= verilator
TOP        := tb_video_pattern
DUT_TOP    := video_pattern_top
FILELIST   := build.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the exit status of the pipe
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_video_pattern.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_video_pattern;
    import video_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;                       // 1092 per frame
    localparam int WATCHDOG_NS  = (6 * FRAME_CYCLES + 2000) * CLK_PERIOD;  // Six frames plus AXI

    logic                       pix_clk;
    logic                       rst;
    logic [AXI_ADDR_BITS-1:0]   s_axil_awaddr;
    logic                       s_axil_awvalid;
    logic                       s_axil_awready;
    logic [AXI_DATA_BITS-1:0]   s_axil_wdata;
    logic [AXI_DATA_BITS/8-1:0] s_axil_wstrb;
    logic                       s_axil_wvalid;
    logic                       s_axil_wready;
    logic [1:0]                 s_axil_bresp;
    logic                       s_axil_bvalid;
    logic                       s_axil_bready;
    logic [AXI_ADDR_BITS-1:0]   s_axil_araddr;
    logic                       s_axil_arvalid;
    logic                       s_axil_arready;
    logic [AXI_DATA_BITS-1:0]   s_axil_rdata;
    logic [1:0]                 s_axil_rresp;
    logic                       s_axil_rvalid;
    logic                       s_axil_rready;
    logic                       hs;
    logic                       vs;
    logic                       de;
    logic [COLOR_DEPTH-1:0]     r;
    logic [COLOR_DEPTH-1:0]     g;
    logic [COLOR_DEPTH-1:0]     b;
    logic [15:0]                lfsr_state;     // Colour source for the solid test

    video_pattern_top dut0 (.*);

    initial
    begin
        pix_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pix_clk = ~pix_clk;
    end

    // Hard stop if a handshake never completes
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the DUT stopped responding or the tests ran too long");
        $display("tests failed");
        $fatal(1, "Timeout");
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else
        begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    // Order 0 sends AW and W together, 1 sends AW first, 2 sends W first
    task automatic axi_write(input string name, input logic [AXI_ADDR_BITS-1:0] addr,
                             input logic [31:0] data, input int order,
                             input logic [1:0] exp_resp);
        logic aw_seen;
        logic w_seen;
        logic aw_hit;
        logic w_hit;
        aw_seen = 1'b0;
        w_seen  = 1'b0;
        @(negedge pix_clk);
        s_axil_awaddr = addr;
        s_axil_wdata  = data;
        s_axil_wstrb  = 4'hF;
        while (!(aw_seen && w_seen))
        begin
            s_axil_awvalid = !aw_seen && (order != 2 || w_seen);
            s_axil_wvalid  = !w_seen && (order != 1 || aw_seen);
            aw_hit = s_axil_awvalid && s_axil_awready;     // Transfer at the next edge
            w_hit  = s_axil_wvalid && s_axil_wready;
            @(negedge pix_clk);
            aw_seen = aw_seen || aw_hit;
            w_seen  = w_seen || w_hit;
        end
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid)
            @(negedge pix_clk);
        check_value({name, " bresp"}, 32'(exp_resp), 32'(s_axil_bresp));
        // No new write accepted while the response waits
        check_value({name, " ready with B pending"}, 32'h0,
                    32'({s_axil_awready, s_axil_wready}));
        s_axil_bready = 1'b1;                               // B held one cycle before this
        @(negedge pix_clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axi_read(input string name, input logic [AXI_ADDR_BITS-1:0] addr,
                            input logic [1:0] exp_resp, output logic [31:0] data);
        logic hit;
        hit = 1'b0;
        @(negedge pix_clk);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        while (!hit)
        begin
            hit = s_axil_arready;
            @(negedge pix_clk);
        end
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid)
            @(negedge pix_clk);
        data = s_axil_rdata;
        check_value({name, " rresp"}, 32'(exp_resp), 32'(s_axil_rresp));
        check_value({name, " arready with R pending"}, 32'h0, 32'(s_axil_arready));
        s_axil_rready = 1'b1;
        @(negedge pix_clk);
        s_axil_rready = 1'b0;
    endtask

    // Restart the raster, return on the first sample of the new frame
    task automatic start_pattern(input string name, input pattern_mode_t mode);
        int wait_cycles;
        wait_cycles = 0;
        axi_write(name, ADDR_CTRL, 32'h0, 0, RESP_OKAY);
        axi_write(name, ADDR_CTRL, {29'h0, mode, 1'b1}, 0, RESP_OKAY);
        while (!hs && wait_cycles < 16)
        begin
            @(negedge pix_clk);
            wait_cycles++;
        end
        check_value({name, " hs delay"}, 32'd1, 32'(wait_cycles));  // Two edges after enable
    endtask

    task automatic scan_frames(input string name, input pattern_mode_t mode,
                               input logic [23:0] solid, input int cycles, output int vs_rises);
        int          col;
        int          de_count;
        logic        prev_de;
        logic        prev_vs;
        logic [7:0]  lvl;
        logic [23:0] exp_rgb;
        col      = 0;
        de_count = 0;
        prev_de  = 1'b0;
        prev_vs  = 1'b0;
        vs_rises = 0;
        for (int t = 0; t < cycles; t++)
        begin
            if (de && !prev_de)
                col = 0;                                // Column restarts at each de rise
            else if (de)
                col++;
            if (vs && !prev_vs)
                vs_rises++;
            lvl     = 8'(col * 4);
            exp_rgb = '0;                               // Blanking is black
            if (de)
            begin
                de_count++;
                case (mode)
                    PAT_SOLID: exp_rgb = solid;
                    PAT_BARS:  exp_rgb = BAR_COLORS[3'(col / BAR_WIDTH)];
                    PAT_RAMP:  exp_rgb = {lvl, lvl, lvl};
                    default:   exp_rgb = '0;
                endcase
            end
            check_value(name, 32'(exp_rgb), 32'({r, g, b}));
            prev_de = de;
            prev_vs = vs;
            @(negedge pix_clk);
        end
        check_value({name, " de count"}, 32'((cycles / FRAME_CYCLES) * H_ACT * V_ACT),
                    32'(de_count));
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_idle();
        logic [31:0] data;
        check_value("idle valid", 32'h0, 32'({s_axil_bvalid, s_axil_rvalid}));
        for (int t = 0; t < FRAME_CYCLES; t++)
        begin
            check_value("idle sync", 32'h0, 32'({hs, vs, de}));
            check_value("idle rgb", 32'h0, 32'({r, g, b}));
            @(negedge pix_clk);
        end
        axi_read("idle ctrl", ADDR_CTRL, RESP_OKAY, data);
        check_value("idle ctrl", 32'h0, data);
    endtask

    task automatic test_regs();
        logic [31:0] data;
        axi_write("regs solid", ADDR_SOLID, 32'h00A1B2C3, 1, RESP_OKAY);
        axi_write("regs ctrl", ADDR_CTRL, 32'h4, 2, RESP_OKAY);    // Bars, output off
        for (int order = 1; order <= 2; order++)
        begin
            axi_write("regs unmapped write", 4'hC, 32'hFFFF_FFFF, order, RESP_SLVERR);
            axi_write("regs frames write", ADDR_FRAMES, 32'h1234, order, RESP_SLVERR);
            axi_read("regs unmapped read", 4'hC, RESP_SLVERR, data);
            axi_read("regs solid", ADDR_SOLID, RESP_OKAY, data);
            check_value("regs solid", 32'h00A1B2C3, data);
            axi_read("regs ctrl", ADDR_CTRL, RESP_OKAY, data);
            check_value("regs ctrl", 32'h4, data);
            axi_read("regs frames", ADDR_FRAMES, RESP_OKAY, data);
            check_value("regs frames", 32'h0, data);            // Never enabled so far
        end
    endtask

    task automatic test_raster();
        int hpos;
        int de_line;
        int act_lines;
        int vs_cycles;
        de_line   = 0;
        act_lines = 0;
        vs_cycles = 0;
        start_pattern("raster", PAT_BARS);
        for (int t = 0; t < FRAME_CYCLES; t++)
        begin
            hpos = t % H_TOTAL;
            check_value("raster hs", 32'(hpos < H_SYNC), 32'(hs));  // Sync opens each line
            if (vs)
                vs_cycles++;
            if (de)
                de_line++;
            if (hpos == H_TOTAL - 1)
            begin
                if (de_line != 0)
                begin
                    check_value("raster de per line", H_ACT, de_line);
                    act_lines++;
                end
                de_line = 0;
            end
            @(negedge pix_clk);
        end
        check_value("raster active lines", V_ACT, act_lines);
        check_value("raster vs length", V_SYNC * H_TOTAL, vs_cycles);
    endtask

    task automatic test_bars_ramp();
        int rises;
        start_pattern("bars", PAT_BARS);
        scan_frames("bars", PAT_BARS, 24'h0, FRAME_CYCLES, rises);
        start_pattern("ramp", PAT_RAMP);
        scan_frames("ramp", PAT_RAMP, 24'h0, FRAME_CYCLES, rises);
    endtask

    task automatic test_solid_frames();
        logic [31:0] color;
        logic [31:0] data;
        logic [31:0] f0;
        logic [31:0] f1;
        int          rises;
        axi_write("solid ctrl", ADDR_CTRL, 32'h0, 0, RESP_OKAY);   // Freeze the frame count
        random_bits(24, color);
        axi_write("solid color", ADDR_SOLID, color, 0, RESP_OKAY);
        axi_read("solid color", ADDR_SOLID, RESP_OKAY, data);
        check_value("solid color", color, data);
        axi_read("frames before", ADDR_FRAMES, RESP_OKAY, f0);
        start_pattern("solid", PAT_SOLID);
        // One extra sample so the third frame start is seen on vs
        scan_frames("solid", PAT_SOLID, color[23:0], 2 * FRAME_CYCLES + 1, rises);
        axi_read("frames after", ADDR_FRAMES, RESP_OKAY, f1);
        check_value("frames count", 32'(16'(f0 + rises)), f1);
    endtask

    initial
    begin
        rst            = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        lfsr_state     = 16'd48;
        repeat (3) @(negedge pix_clk);
        rst = 1'b0;
        test_idle();
        test_regs();
        test_raster();
        test_bars_ramp();
        test_solid_frames();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/video_pattern_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_pattern_top (
    input  wire                                         pix_clk,
    input  wire                                         rst,
    input  wire [video_pkg::AXI_ADDR_BITS-1:0]          s_axil_awaddr,
    input  wire                                         s_axil_awvalid,
    output logic                                        s_axil_awready,
    input  wire [video_pkg::AXI_DATA_BITS-1:0]          s_axil_wdata,
    input  wire [video_pkg::AXI_DATA_BITS/8-1:0]        s_axil_wstrb,
    input  wire                                         s_axil_wvalid,
    output logic                                        s_axil_wready,
    output logic [1:0]                                  s_axil_bresp,
    output logic                                        s_axil_bvalid,
    input  wire                                         s_axil_bready,
    input  wire [video_pkg::AXI_ADDR_BITS-1:0]          s_axil_araddr,
    input  wire                                         s_axil_arvalid,
    output logic                                        s_axil_arready,
    output logic [video_pkg::AXI_DATA_BITS-1:0]         s_axil_rdata,
    output logic [1:0]                                  s_axil_rresp,
    output logic                                        s_axil_rvalid,
    input  wire                                         s_axil_rready,
    output logic                                        hs,
    output logic                                        vs,
    output logic                                        de,
    output logic [video_pkg::COLOR_DEPTH-1:0]           r,
    output logic [video_pkg::COLOR_DEPTH-1:0]           g,
    output logic [video_pkg::COLOR_DEPTH-1:0]           b
);
    import video_pkg::*;

    logic              enable;
    pattern_mode_t     mode;
    logic [23:0]       solid_rgb;
    logic [X_BITS-1:0] h_cnt;
    logic [Y_BITS-1:0] v_cnt;
    logic              frame_start;    // To the FSM and the frame counter

    video_if vid0 ();

    axil_regs regs0 (
        .pix_clk        (pix_clk),
        .rst            (rst),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .enable         (enable),
        .mode           (mode),
        .solid_rgb      (solid_rgb),
        .frame_start    (frame_start)
    );

    raster_counter cnt0 (
        .pix_clk     (pix_clk),
        .rst         (rst),
        .enable      (enable),
        .h_cnt       (h_cnt),
        .v_cnt       (v_cnt),
        .frame_start (frame_start)
    );

    // Counter to outputs is two register stages
    sync_fsm fsm0 (
        .pix_clk     (pix_clk),
        .rst         (rst),
        .h_cnt       (h_cnt),
        .v_cnt       (v_cnt),
        .frame_start (frame_start),
        .vid         (vid0.source)
    );

    pattern_gen pat0 (
        .pix_clk   (pix_clk),
        .rst       (rst),
        .vid       (vid0.sink),
        .mode      (mode),
        .solid_rgb (solid_rgb),
        .hs_out    (hs),
        .vs_out    (vs),
        .de_out    (de),
        .r_out     (r),
        .g_out     (g),
        .b_out     (b)
    );

endmodule

`default_nettype wire

// ==== design/axil_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_regs (
    input  wire                                         pix_clk,
    input  wire                                         rst,
    input  wire [video_pkg::AXI_ADDR_BITS-1:0]          s_axil_awaddr,
    input  wire                                         s_axil_awvalid,
    output logic                                        s_axil_awready,
    input  wire [video_pkg::AXI_DATA_BITS-1:0]          s_axil_wdata,
    input  wire [video_pkg::AXI_DATA_BITS/8-1:0]        s_axil_wstrb,
    input  wire                                         s_axil_wvalid,
    output logic                                        s_axil_wready,
    output logic [1:0]                                  s_axil_bresp,
    output logic                                        s_axil_bvalid,
    input  wire                                         s_axil_bready,
    input  wire [video_pkg::AXI_ADDR_BITS-1:0]          s_axil_araddr,
    input  wire                                         s_axil_arvalid,
    output logic                                        s_axil_arready,
    output logic [video_pkg::AXI_DATA_BITS-1:0]         s_axil_rdata,
    output logic [1:0]                                  s_axil_rresp,
    output logic                                        s_axil_rvalid,
    input  wire                                         s_axil_rready,
    output logic                                        enable,
    output video_pkg::pattern_mode_t                    mode,
    output logic [23:0]                                 solid_rgb,
    input  wire                                         frame_start
);
    import video_pkg::*;

    logic                       aw_done;    // Address accepted, waiting for data
    logic                       w_done;     // Data accepted, waiting for address
    logic [AXI_ADDR_BITS-1:0]   wr_addr;
    logic [AXI_DATA_BITS-1:0]   wr_data;
    logic [AXI_DATA_BITS/8-1:0] wr_strb;
    logic                       wr_fire;
    logic                       wr_ok;
    logic [AXI_DATA_BITS-1:0]   rd_data;
    logic                       rd_ok;
    logic [15:0]                frames;

    // Back-pressure while a B response is pending
    assign s_axil_awready = !aw_done && !s_axil_bvalid;
    assign s_axil_wready  = !w_done && !s_axil_bvalid;
    assign s_axil_arready = !s_axil_rvalid;    // One read in flight

    assign wr_fire = aw_done && w_done;
    assign wr_ok   = (wr_addr == ADDR_CTRL) || (wr_addr == ADDR_SOLID); // FRAMES is RO

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    always_ff @(posedge pix_clk)
    begin
        if (s_axil_awvalid && s_axil_awready)
            wr_addr <= s_axil_awaddr;
        if (s_axil_wvalid && s_axil_wready)
        begin
            wr_data <= s_axil_wdata;
            wr_strb <= s_axil_wstrb;
        end
    end

    always_ff @(posedge pix_clk)
    begin
        if (rst)
        begin
            aw_done       <= 1'b0;
            w_done        <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_bresp  <= RESP_OKAY;
            enable        <= 1'b0;
            mode          <= PAT_BLACK;
            solid_rgb     <= '0;
        end
        else
        begin
            if (s_axil_awvalid && s_axil_awready)
                aw_done <= 1'b1;
            if (s_axil_wvalid && s_axil_wready)
                w_done <= 1'b1;
            if (wr_fire)                         // Both halves in, either order
            begin
                aw_done       <= 1'b0;
                w_done        <= 1'b0;
                s_axil_bvalid <= 1'b1;
                s_axil_bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                if (wr_addr == ADDR_CTRL && wr_strb[0])
                begin
                    enable <= wr_data[0];
                    mode   <= pattern_mode_t'(wr_data[2:1]);
                end
                if (wr_addr == ADDR_SOLID)
                begin
                    for (int i = 0; i < 3; i++)  // Byte lanes B, G, R
                        if (wr_strb[i])
                            solid_rgb[i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
            else if (s_axil_bvalid && s_axil_bready)
            begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    always_comb
    begin
        rd_data = '0;
        rd_ok   = 1'b1;
        case (s_axil_araddr)
            ADDR_CTRL:   rd_data[2:0]  = {mode, enable};
            ADDR_SOLID:  rd_data[23:0] = solid_rgb;
            ADDR_FRAMES: rd_data[15:0] = frames;
            default:     rd_ok         = 1'b0;     // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge pix_clk)
    begin
        if (s_axil_arvalid && s_axil_arready)
            s_axil_rdata <= rd_data;
    end

    always_ff @(posedge pix_clk)
    begin
        if (rst)
        begin
            s_axil_rvalid <= 1'b0;
            s_axil_rresp  <= RESP_OKAY;
        end
        else if (s_axil_arvalid && s_axil_arready)
        begin
            s_axil_rvalid <= 1'b1;
            s_axil_rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
        else if (s_axil_rvalid && s_axil_rready)
        begin
            s_axil_rvalid <= 1'b0;
        end
    end

    // Frame count, wraps at 16 bits
    always_ff @(posedge pix_clk)
    begin
        if (rst)
            frames <= '0;
        else if (frame_start)
            frames <= frames + 1'b1;
    end

    a_b_hold: assert property (@(posedge pix_clk) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp));
    a_r_hold: assert property (@(posedge pix_clk) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

`default_nettype wire

// ==== design/pattern_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module pattern_gen (
    input  wire                                 pix_clk,
    input  wire                                 rst,
    video_if.sink                               vid,
    input  wire video_pkg::pattern_mode_t       mode,
    input  wire [23:0]                          solid_rgb,
    output logic                                hs_out,
    output logic                                vs_out,
    output logic                                de_out,
    output logic [video_pkg::COLOR_DEPTH-1:0]   r_out,
    output logic [video_pkg::COLOR_DEPTH-1:0]   g_out,
    output logic [video_pkg::COLOR_DEPTH-1:0]   b_out
);
    import video_pkg::*;

    logic [2:0]             bar_idx;    // One of eight bars
    logic [COLOR_DEPTH-1:0] ramp;       // Gray level for this column
    logic [23:0]            pix;        // Packed R G B

    assign bar_idx = 3'(vid.act_x / X_BITS'(BAR_WIDTH));
    assign ramp    = COLOR_DEPTH'({vid.act_x, 2'b00}); // Column times 4

    // --------------------------------------------------
    // Colour select by pattern mode
    // --------------------------------------------------
    always_comb
    begin
        case (mode)
            PAT_BLACK: pix = '0;
            PAT_SOLID: pix = solid_rgb;
            PAT_BARS:  pix = BAR_COLORS[bar_idx];
            PAT_RAMP:  pix = {ramp, ramp, ramp};
            default:   pix = '0;
        endcase
    end

    // Single register stage, syncs delayed along with the pixel
    always_ff @(posedge pix_clk)
    begin
        if (rst)
        begin
            hs_out <= 1'b0;
            vs_out <= 1'b0;
            de_out <= 1'b0;
            r_out  <= '0;
            g_out  <= '0;
            b_out  <= '0;
        end
        else
        begin
            hs_out <= vid.hs;
            vs_out <= vid.vs;
            de_out <= vid.de;
            if (vid.de)
            begin
                r_out <= pix[23:16];
                g_out <= pix[15:8];
                b_out <= pix[7:0];
            end
            else
            begin
                r_out <= '0;                     // Blanking is black
                g_out <= '0;
                b_out <= '0;
            end
        end
    end

    a_blank_black: assert property (@(posedge pix_clk) disable iff (rst)
        !de_out |-> ({r_out, g_out, b_out} == '0));

endmodule

`default_nettype wire

// ==== design/sync_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_fsm (
    input  wire                             pix_clk,
    input  wire                             rst,
    input  wire [video_pkg::X_BITS-1:0]     h_cnt,
    input  wire [video_pkg::Y_BITS-1:0]     v_cnt,
    input  wire                             frame_start,
    video_if.source                         vid
);
    import video_pkg::*;

    h_phase_t h_state;
    h_phase_t h_next;
    v_phase_t v_state;
    v_phase_t v_next;
    logic     run_line;    // Zero count is a real line start, not an idle counter
    logic     in_act;

    // Stopped counters sit at 0,0 without frame_start
    assign run_line = (v_cnt != '0) || frame_start;
    assign in_act   = (h_next == HP_ACTIVE) && (v_next == VP_ACTIVE);

    // --------------------------------------------------
    // Horizontal phase, stepped by pixel position
    // --------------------------------------------------
    always_comb
    begin
        h_next = h_state;
        case (h_cnt)
            '0:                    h_next = run_line ? HP_SYNC : HP_FRONT;
            X_BITS'(H_SYNC):       h_next = HP_BACK;
            X_BITS'(H_ACT_START):  h_next = HP_ACTIVE;
            X_BITS'(H_FP_START):   h_next = HP_FRONT;
            default:               h_next = h_state;
        endcase
    end

    // --------------------------------------------------
    // Vertical phase, only at the line wrap
    // --------------------------------------------------
    always_comb
    begin
        v_next = v_state;
        if (h_cnt == '0)
        begin
            case (v_cnt)
                '0:                    v_next = frame_start ? VP_SYNC : VP_FRONT;
                Y_BITS'(V_SYNC):       v_next = VP_BACK;
                Y_BITS'(V_ACT_START):  v_next = VP_ACTIVE;
                Y_BITS'(V_FP_START):   v_next = VP_FRONT;
                default:               v_next = v_state;
            endcase
        end
    end

    always_ff @(posedge pix_clk)
    begin
        if (rst)
        begin
            h_state   <= HP_FRONT;               // Quiet phase, all strobes low
            v_state   <= VP_FRONT;
            vid.hs    <= 1'b0;
            vid.vs    <= 1'b0;
            vid.de    <= 1'b0;
            vid.act_x <= '0;
            vid.act_y <= '0;
        end
        else
        begin
            h_state <= h_next;
            v_state <= v_next;
            vid.hs  <= (h_next == HP_SYNC);
            vid.vs  <= (v_next == VP_SYNC);      // Whole lines, aligned with hs
            vid.de  <= in_act;
            // Offsets into the active area, 0 elsewhere
            vid.act_x <= in_act ? h_cnt - X_BITS'(H_ACT_START) : '0;
            vid.act_y <= in_act ? v_cnt - Y_BITS'(V_ACT_START) : '0;
        end
    end

    a_de_x: assert property (@(posedge pix_clk) disable iff (rst)
        vid.de |-> vid.act_x < X_BITS'(H_ACT));

    // Sync sits outside the active area
    a_hs_de: assert property (@(posedge pix_clk) disable iff (rst)
        !(vid.hs && vid.de));

endmodule

`default_nettype wire

// ==== design/raster_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module raster_counter (
    input  wire                             pix_clk,
    input  wire                             rst,
    input  wire                             enable,
    output logic [video_pkg::X_BITS-1:0]    h_cnt,
    output logic [video_pkg::Y_BITS-1:0]    v_cnt,
    output logic                            frame_start
);
    import video_pkg::*;

    logic h_last;    // Last pixel of the line
    logic v_last;    // Last line of the frame

    assign h_last = (h_cnt == X_BITS'(H_TOTAL - 1));
    assign v_last = (v_cnt == Y_BITS'(V_TOTAL - 1));

    // Top-left of the raster while running, also the first enabled cycle
    assign frame_start = enable && (h_cnt == '0) && (v_cnt == '0);

    always_ff @(posedge pix_clk)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (!enable)
        begin
            h_cnt <= '0;                        // Held so the next enable starts a frame
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1; // Next line, or wrap the frame
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Counter never runs past the end of a line
    a_h_range: assert property (@(posedge pix_clk) disable iff (rst)
        h_cnt < X_BITS'(H_TOTAL));

endmodule

`default_nettype wire

// ==== design/video_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Timing and active-area position, one pixel per pix_clk
interface video_if;
    import video_pkg::*;

    logic              hs;
    logic              vs;
    logic              de;
    logic [X_BITS-1:0] act_x;    // Column inside the active area
    logic [Y_BITS-1:0] act_y;    // Line inside the active area

    modport source (
        output hs,
        output vs,
        output de,
        output act_x,
        output act_y
    );

    modport sink (
        input hs,
        input vs,
        input de,
        input act_x,
        input act_y
    );

endinterface

`default_nettype wire

// ==== design/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // --------------------------------------------------
    // Raster timing, small enough for simulation
    // --------------------------------------------------
    localparam int H_ACT   = 64;                        // Active pixels per line
    localparam int H_FP    = 4;
    localparam int H_SYNC  = 8;
    localparam int H_BP    = 8;
    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP; // 84

    localparam int V_ACT   = 8;                         // Active lines per frame
    localparam int V_FP    = 1;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 2;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP; // 13

    // Phase boundaries, counted from the start of sync
    localparam int H_ACT_START = H_SYNC + H_BP;
    localparam int H_FP_START  = H_ACT_START + H_ACT;
    localparam int V_ACT_START = V_SYNC + V_BP;
    localparam int V_FP_START  = V_ACT_START + V_ACT;

    localparam int X_BITS      = 13;
    localparam int Y_BITS      = 13;
    localparam int COLOR_DEPTH = 8;                     // Bits per channel

    // --------------------------------------------------
    // Colours
    // --------------------------------------------------
    localparam int BAR_WIDTH = H_ACT / 8;
    localparam logic [23:0] BAR_COLORS [8] = '{
        24'hFF_FF_FF, 24'hFF_FF_00, 24'h00_FF_FF, 24'h00_FF_00,  // White yellow cyan green
        24'hFF_00_FF, 24'hFF_00_00, 24'h00_00_FF, 24'h00_00_00   // Magenta red blue black
    };
    localparam logic [COLOR_DEPTH-1:0] GRAY_LEVEL = 8'd85;

    // --------------------------------------------------
    // AXI4-Lite register map
    // --------------------------------------------------
    localparam int AXI_ADDR_BITS = 4;
    localparam int AXI_DATA_BITS = 32;

    localparam logic [AXI_ADDR_BITS-1:0] ADDR_CTRL   = 4'h0; // [0] enable, [2:1] mode
    localparam logic [AXI_ADDR_BITS-1:0] ADDR_SOLID  = 4'h4; // R in [23:16]
    localparam logic [AXI_ADDR_BITS-1:0] ADDR_FRAMES = 4'h8; // Read only

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        PAT_BLACK = 2'd0,
        PAT_SOLID = 2'd1,
        PAT_BARS  = 2'd2,
        PAT_RAMP  = 2'd3
    } pattern_mode_t;

    typedef enum logic [1:0] {HP_SYNC, HP_BACK, HP_ACTIVE, HP_FRONT} h_phase_t;
    typedef enum logic [1:0] {VP_SYNC, VP_BACK, VP_ACTIVE, VP_FRONT} v_phase_t;

endpackage

`default_nettype wire
